// ==== list.f ====
verilog/procPkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/writeback.sv
verilog/proc.sv
test/procTb.sv

// ==== Makefile ====
TOP = procTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f list.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^TB PASSED$$'

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== test/procTb.sv ====
`timescale 1ns/1ns

module procTb;

   import procPkg::*;

   localparam int resetCycles = 8;
   localparam int haltWait    = 5;

   logic              clk;
   logic              rstN;
   logic              progWe;
   logic [iAddrW-1:0] progAddr;
   logic [15:0]       progData;
   logic              halted;
   logic              err;
   logic              regWrEn;
   logic [2:0]        regWrAddr;
   logic [15:0]       regWrData;

   // Program words and the state of the reference model
   logic [15:0] prog [$];
   logic [15:0] modelRegs [8];
   logic [15:0] modelMem [dMemWords];
   logic [15:0] modelPc;
   int unsigned lcgState = 74309;
   int          cycleCount = 0;
   int          cycleLimit = 40;

   proc u_dut (
      .clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .halted(halted), .err(err), .regWrEn(regWrEn), .regWrAddr(regWrAddr),
      .regWrData(regWrData)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Run limit grows with every program that is loaded
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount > cycleLimit) begin
         $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
         $display("TB FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [15:0] randWord();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[30:15];
   endfunction

   // Instruction encoders, formats as in the ISA
   function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rs,
                                         input logic [2:0] rd, input logic [4:0] imm5);
      return {op, rs, rd, imm5};
   endfunction

   function automatic logic [15:0] encR(input logic [2:0] rs, input logic [2:0] rt,
                                         input logic [2:0] rd, input logic [1:0] func);
      return {opAlur, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] encI8(input logic [4:0] op, input logic [2:0] r,
                                          input logic [7:0] imm8);
      return {op, r, imm8};
   endfunction

   task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("TB FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   // Loader writes one word per cycle, reset held low for at least 8 cycles
   task automatic loadProgram();
      cycleLimit += 3 * prog.size() + resetCycles + haltWait + 4;
      rstN = 1'b0;
      for (int i = 0; i < prog.size() || i < resetCycles; i++) begin
         progWe   = (i < prog.size());
         progAddr = iAddrW'(i);
         progData = (i < prog.size()) ? prog[i] : 16'h0000;
         @(negedge clk);
      end
      progWe = 1'b0;
   endtask

   // Reference model executes one instruction and checks this cycle's commit
   task automatic stepModel(output bit haltSeen);
      logic [15:0] ins;
      logic [15:0] s5;
      logic [15:0] z5;
      logic [15:0] s8;
      logic [15:0] s11;
      logic [15:0] addr;
      logic [15:0] val;
      logic [15:0] nxt;
      logic [4:0]  op;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  rd;
      logic [2:0]  dst;
      logic        expWe;
      logic        expErr;
      int          idx;
      idx = int'(modelPc[15:1]);
      if (idx >= prog.size()) begin
         $display("Reference model left the program at PC %h", modelPc);
         $display("TB FAILED");
         $fatal(1, "bad PC");
      end
      ins = prog[idx];
      op  = ins[15:11];
      rs  = ins[10:8];
      // Bits 7 to 5 are rt in R-format and the destination in I-format
      rt  = ins[7:5];
      rd  = ins[4:2];
      s5  = {{11{ins[4]}}, ins[4:0]};
      z5  = {11'b0, ins[4:0]};
      s8  = {{8{ins[7]}}, ins[7:0]};
      s11 = {{5{ins[10]}}, ins[10:0]};
      addr = modelRegs[rs] + s5;
      nxt  = modelPc + 16'd2;
      expWe  = 1'b1;
      expErr = 1'b0;
      dst    = rt;
      val    = 16'h0000;
      case (op)
         opHalt, opNop: expWe = 1'b0;
         opJ: begin
            expWe = 1'b0;
            nxt   = nxt + (s11 << 1);
         end
         opAddi:  val = modelRegs[rs] + s5;
         opSubi:  val = s5 - modelRegs[rs];
         opXori:  val = modelRegs[rs] ^ z5;
         opAndni: val = modelRegs[rs] & ~z5;
         opBeqz, opBnez: begin
            expWe = 1'b0;
            if ((modelRegs[rs] == 16'h0000) == (op == opBeqz)) nxt = nxt + (s8 << 1);
         end
         opSt: begin
            expWe = 1'b0;
            modelMem[addr[8:1]] = modelRegs[rt];
         end
         opLd: val = modelMem[addr[8:1]];
         opSlbi: begin
            dst = rs;
            val = (modelRegs[rs] << 8) | {8'b0, ins[7:0]};
         end
         opLbi: begin
            dst = rs;
            val = s8;
         end
         opAlur: begin
            dst = rd;
            case (ins[1:0])
               2'b00:   val = modelRegs[rs] + modelRegs[rt];
               2'b01:   val = modelRegs[rs] - modelRegs[rt];
               2'b10:   val = modelRegs[rs] ^ modelRegs[rt];
               default: val = modelRegs[rs] & ~modelRegs[rt];
            endcase
         end
         default: begin
            expWe  = 1'b0;
            expErr = 1'b1;
         end
      endcase
      checkValue(16'(halted), 16'h0, "halted while running");
      checkValue(16'(err), 16'(expErr), "err");
      checkValue(16'(regWrEn), 16'(expWe), "regWrEn");
      if (expWe) begin
         checkValue(16'(regWrAddr), 16'(dst), "regWrAddr");
         checkValue(regWrData, val, "regWrData");
         modelRegs[dst] = val;
      end
      modelPc  = nxt;
      haltSeen = (op == opHalt);
   endtask

   task automatic runProgram();
      bit haltSeen;
      modelPc  = 16'h0000;
      haltSeen = 1'b0;
      foreach (modelRegs[i]) begin
         modelRegs[i] = 16'h0000;
      end
      rstN = 1'b1;
      while (!haltSeen) begin
         stepModel(haltSeen);
         @(negedge clk);
      end
      // Halted from the HALT edge on, and the core stays idle
      repeat (haltWait) begin
         checkValue(16'(halted), 16'h1, "halted after HALT");
         checkValue(16'(regWrEn), 16'h0, "regWrEn after HALT");
         checkValue(16'(err), 16'h0, "err after HALT");
         @(negedge clk);
      end
      rstN = 1'b0;
   endtask

   task automatic immOpsTest();
      logic [15:0] w;
      prog.delete();
      for (int r = 0; r < 8; r++) begin
         w = randWord();
         prog.push_back(encI8(opLbi, 3'(r), w[7:0]));
      end
      // Bits 12 and 11 choose among ADDI, SUBI, XORI and ANDNI
      for (int n = 0; n < 16; n++) begin
         w = randWord();
         prog.push_back(encI({3'b010, w[12:11]}, w[2:0], w[5:3], w[10:6]));
      end
      // Fixed cases on r0 = ff80 for SUBI order and the zero-extended imm5
      prog.push_back(encI8(opLbi, 3'd0, 8'h80));
      prog.push_back(encI(opSubi, 3'd0, 3'd3, 5'd1));
      prog.push_back(encI(opXori, 3'd0, 3'd2, 5'h1f));
      prog.push_back(encI(opAndni, 3'd0, 3'd1, 5'h1f));
      for (int n = 0; n < 3; n++) begin
         w = randWord();
         prog.push_back(encI8(opSlbi, w[10:8], w[7:0]));
      end
      prog.push_back({opHalt, 11'd0});
      loadProgram();
      runProgram();
   endtask

   task automatic regOpsTest();
      logic [15:0] w;
      prog.delete();
      // Full 16-bit random value per register from LBI then SLBI
      for (int r = 0; r < 8; r++) begin
         w = randWord();
         prog.push_back(encI8(opLbi, 3'(r), w[15:8]));
         prog.push_back(encI8(opSlbi, 3'(r), w[7:0]));
      end
      for (int n = 0; n < 16; n++) begin
         w = randWord();
         prog.push_back(encR(w[2:0], w[5:3], w[8:6], w[10:9]));
      end
      prog.push_back({opHalt, 11'd0});
      loadProgram();
      runProgram();
   endtask

   task automatic loadStoreTest();
      logic [15:0] w;
      logic [4:0]  offs [4];
      prog.delete();
      w = randWord();
      prog.push_back(encI8(opLbi, 3'd1, w[7:0]));
      for (int n = 0; n < 4; n++) begin
         w = randWord();
         offs[n] = w[4:0];
         prog.push_back(encI8(opLbi, 3'(n + 2), w[15:8]));
         prog.push_back(encI8(opSlbi, 3'(n + 2), w[12:5]));
         prog.push_back(encI(opSt, 3'd1, 3'(n + 2), offs[n]));
      end
      // Read back in store order, alternating destinations r6 and r7
      for (int n = 0; n < 4; n++) begin
         prog.push_back(encI(opLd, 3'd1, 3'(6 + n % 2), offs[n]));
      end
      prog.push_back({opHalt, 11'd0});
      loadProgram();
      runProgram();
   endtask

   task automatic branchTest();
      prog.delete();
      prog.push_back(encI8(opLbi, 3'd0, 8'd0));
      prog.push_back(encI8(opLbi, 3'd1, 8'd5));
      prog.push_back(encI8(opBeqz, 3'd0, 8'd2));
      prog.push_back(encI8(opLbi, 3'd2, 8'd1));
      prog.push_back(encI8(opLbi, 3'd2, 8'd2));
      prog.push_back(encI8(opLbi, 3'd3, 8'd3));
      prog.push_back(encI8(opBnez, 3'd0, 8'd1));
      prog.push_back(encI8(opBnez, 3'd1, 8'd1));
      prog.push_back(encI8(opLbi, 3'd2, 8'd7));
      prog.push_back(encI8(opBeqz, 3'd1, 8'd1));
      prog.push_back({opJ, 11'd1});
      prog.push_back(encI8(opLbi, 3'd2, 8'd9));
      // Count-down loop with a backward BNEZ
      prog.push_back(encI8(opLbi, 3'd4, 8'd3));
      prog.push_back(encI(opAddi, 3'd4, 3'd4, 5'h1f));
      prog.push_back(encI8(opBnez, 3'd4, 8'hfe));
      prog.push_back({opHalt, 11'd0});
      loadProgram();
      runProgram();
   endtask

   task automatic illegalOpTest();
      prog.delete();
      prog.push_back(encI8(opLbi, 3'd1, 8'd7));
      prog.push_back({5'b00010, 11'h2a5});
      prog.push_back(encI(opAddi, 3'd1, 3'd2, 5'd1));
      prog.push_back({5'b11111, 11'h13c});
      prog.push_back(encI(opAddi, 3'd2, 3'd3, 5'h1d));
      prog.push_back({opHalt, 11'd0});
      loadProgram();
      runProgram();
   endtask

   initial begin
      rstN     = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = 16'h0000;
      immOpsTest();
      regOpsTest();
      loadStoreTest();
      branchTest();
      illegalOpTest();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== verilog/proc.sv ====
`timescale 1ns/1ns

module proc (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic                       progWe,
   input  logic [procPkg::iAddrW-1:0] progAddr,
   input  logic [15:0]                progData,
   output logic                       halted,
   output logic                       err,
   output logic                       regWrEn,
   output logic [2:0]                 regWrAddr,
   output logic [15:0]                regWrData
);

   import procPkg::*;

   // Fetch outputs
   logic [15:0] instruction;
   logic [15:0] pcPlus2;

   // Decode outputs
   opcodeT      opcode;
   aluOpT       aluOp;
   logic [15:0] rsData;
   logic [15:0] rtData;
   logic [15:0] storeData;
   logic [15:0] imm;
   logic        useImm;
   logic        isBranch;
   logic        branchOnZero;
   logic        isJump;
   logic        isHalt;
   logic        storeEn;
   wbSelT       wbSel;

   // Execute and memory outputs
   logic [15:0] aluResult;
   logic [15:0] nextPc;
   logic [15:0] readData;

   fetch iFetch (
      .clk(clk), .rstN(rstN), .nextPc(nextPc), .isHalt(isHalt),
      .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .instruction(instruction), .pcPlus2(pcPlus2), .halted(halted)
   );

   // Register write port doubles as the commit trace
   decode iDecode (
      .clk(clk), .rstN(rstN), .instruction(instruction), .wrData(regWrData),
      .opcode(opcode), .aluOp(aluOp), .rsData(rsData), .rtData(rtData),
      .storeData(storeData), .imm(imm), .useImm(useImm), .isBranch(isBranch),
      .branchOnZero(branchOnZero), .isJump(isJump), .isHalt(isHalt),
      .storeEn(storeEn), .regWrEn(regWrEn), .wrReg(regWrAddr), .wbSel(wbSel),
      .err(err)
   );

   execute iExecute (
      .opcode(opcode), .aluOp(aluOp), .rsData(rsData), .rtData(rtData),
      .imm(imm), .useImm(useImm), .isBranch(isBranch),
      .branchOnZero(branchOnZero), .isJump(isJump), .pcPlus2(pcPlus2),
      .aluResult(aluResult), .nextPc(nextPc)
   );

   // ALU result is the data address
   memory iMemory (
      .clk(clk), .storeEn(storeEn), .address(aluResult),
      .storeData(storeData), .readData(readData)
   );

   writeback iWriteback (
      .wbSel(wbSel), .aluResult(aluResult), .readData(readData),
      .wrData(regWrData)
   );

endmodule

// ==== verilog/writeback.sv ====
`timescale 1ns/1ns

module writeback (
   input  procPkg::wbSelT wbSel,
   input  logic [15:0]    aluResult,
   input  logic [15:0]    readData,
   output logic [15:0]    wrData
);

   import procPkg::*;

   // Loaded word for LD, ALU value for everything else
   always_comb begin
      case (wbSel)
         wbMem:   wrData = readData;
         default: wrData = aluResult;
      endcase
   end

endmodule

// ==== verilog/memory.sv ====
`timescale 1ns/1ns

module memory (
   input  logic        clk,
   input  logic        storeEn,
   input  logic [15:0] address,
   input  logic [15:0] storeData,
   output logic [15:0] readData
);

   import procPkg::*;

   logic [15:0]       dMem [dMemWords];
   logic [dAddrW-1:0] wordIdx;

   // Byte address to word index, bit 0 ignored
   assign wordIdx = address[dAddrW:1];

   // Store lands at the commit edge
   always_ff @(posedge clk) begin
      if (storeEn) begin
         dMem[wordIdx] <= storeData;
      end
   end

   // Combinational load
   assign readData = dMem[wordIdx];

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ns

module execute (
   input  procPkg::opcodeT opcode,
   input  procPkg::aluOpT  aluOp,
   input  logic [15:0]     rsData,
   input  logic [15:0]     rtData,
   input  logic [15:0]     imm,
   input  logic            useImm,
   input  logic            isBranch,
   input  logic            branchOnZero,
   input  logic            isJump,
   input  logic [15:0]     pcPlus2,
   output logic [15:0]     aluResult,
   output logic [15:0]     nextPc
);

   import procPkg::*;

   logic [15:0] opB;
   logic        rsZero;
   logic        takeBranch;
   logic [15:0] target;

   // Operand B from register or immediate
   assign opB = useImm ? imm : rtData;

   // ALU
   always_comb begin
      case (aluOp)
         aluAdd: aluResult = rsData + opB;
         // SUBI takes imm minus rs, register SUB is rs minus rt
         aluSub: begin
            if (opcode == opSubi) begin
               aluResult = opB - rsData;
            end else begin
               aluResult = rsData - opB;
            end
         end
         aluXor:   aluResult = rsData ^ opB;
         aluAndn:  aluResult = rsData & ~opB;
         // LBI
         aluPassB: aluResult = opB;
         // SLBI, imm arrives zero-extended
         aluShlB:  aluResult = (rsData << 8) | opB;
         default:  aluResult = rsData + opB;
      endcase
   end

   // Branch condition on rs
   assign rsZero     = (rsData == 16'h0000);
   assign takeBranch = isBranch && (rsZero == branchOnZero);

   // Offset counts in words, so shift left by one
   assign target = pcPlus2 + {imm[14:0], 1'b0};

   assign nextPc = (takeBranch || isJump) ? target : pcPlus2;

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ns

module decode (
   input  logic            clk,
   input  logic            rstN,
   input  logic [15:0]     instruction,
   input  logic [15:0]     wrData,
   output procPkg::opcodeT opcode,
   output procPkg::aluOpT  aluOp,
   output logic [15:0]     rsData,
   output logic [15:0]     rtData,
   output logic [15:0]     storeData,
   output logic [15:0]     imm,
   output logic            useImm,
   output logic            isBranch,
   output logic            branchOnZero,
   output logic            isJump,
   output logic            isHalt,
   output logic            storeEn,
   output logic            regWrEn,
   output logic [2:0]      wrReg,
   output procPkg::wbSelT  wbSel,
   output logic            err
);

   import procPkg::*;

   logic [2:0]  rsIdx;
   logic [2:0]  rtIdx;
   logic [2:0]  rdIdx;
   logic [15:0] immS5;
   logic [15:0] immZ5;
   logic [15:0] immS8;
   logic [15:0] immZ8;
   logic [15:0] immS11;
   aluFuncT     func;
   logic [15:0] regs [8];

   // Field split
   assign opcode = opcodeT'(instruction[opMsb:opLsb]);
   assign func   = aluFuncT'(instruction[funcMsb:funcLsb]);
   assign rsIdx  = instruction[rsMsb:rsLsb];
   // Second source in R-format, destination in I-format
   assign rtIdx  = instruction[rtMsb:rtLsb];
   assign rdIdx  = instruction[rdMsb:rdLsb];

   // Immediate extenders
   assign immS5  = {{11{instruction[imm5Msb]}}, instruction[imm5Msb:0]};
   assign immZ5  = {11'b0, instruction[imm5Msb:0]};
   assign immS8  = {{8{instruction[imm8Msb]}}, instruction[imm8Msb:0]};
   assign immZ8  = {8'b0, instruction[imm8Msb:0]};
   assign immS11 = {{5{instruction[dispMsb]}}, instruction[dispMsb:0]};

   // Register file reads
   assign rsData    = regs[rsIdx];
   assign rtData    = regs[rtIdx];
   // ST stores the register named in bits 7 to 5
   assign storeData = regs[instruction[rtMsb:rtLsb]];

   // Control decode, anything unlisted is a NOP with err raised
   always_comb begin
      aluOp        = aluAdd;
      imm          = immS5;
      useImm       = 1'b1;
      isBranch     = 1'b0;
      branchOnZero = 1'b0;
      isJump       = 1'b0;
      isHalt       = 1'b0;
      storeEn      = 1'b0;
      regWrEn      = 1'b0;
      wrReg        = rtIdx;
      wbSel        = wbAlu;
      err          = 1'b0;
      case (opcode)
         opHalt: isHalt = 1'b1;
         opNop: ;
         opJ: begin
            imm    = immS11;
            isJump = 1'b1;
         end
         opAddi: regWrEn = 1'b1;
         opSubi: begin
            aluOp   = aluSub;
            regWrEn = 1'b1;
         end
         opXori: begin
            aluOp   = aluXor;
            imm     = immZ5;
            regWrEn = 1'b1;
         end
         opAndni: begin
            aluOp   = aluAndn;
            imm     = immZ5;
            regWrEn = 1'b1;
         end
         opBeqz, opBnez: begin
            imm          = immS8;
            isBranch     = 1'b1;
            branchOnZero = (opcode == opBeqz);
         end
         // Address is rs plus imm5 for both memory ops
         opSt: storeEn = 1'b1;
         opLd: begin
            regWrEn = 1'b1;
            wbSel   = wbMem;
         end
         opSlbi: begin
            aluOp   = aluShlB;
            imm     = immZ8;
            regWrEn = 1'b1;
            wrReg   = rsIdx;
         end
         opLbi: begin
            aluOp   = aluPassB;
            imm     = immS8;
            regWrEn = 1'b1;
            wrReg   = rsIdx;
         end
         opAlur: begin
            useImm  = 1'b0;
            regWrEn = 1'b1;
            wrReg   = rdIdx;
            case (func)
               funcAdd:  aluOp = aluAdd;
               funcSub:  aluOp = aluSub;
               funcXor:  aluOp = aluXor;
               default:  aluOp = aluAndn;
            endcase
         end
         default: err = 1'b1;
      endcase
   end

   // Eight-entry register file, written at the commit edge
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'h0000;
         end
      end else if (regWrEn) begin
         regs[wrReg] <= wrData;
      end
   end

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/1ns

module fetch (
   input  logic                       clk,
   input  logic                       rstN,
   input  logic [15:0]                nextPc,
   input  logic                       isHalt,
   input  logic                       progWe,
   input  logic [procPkg::iAddrW-1:0] progAddr,
   input  logic [15:0]                progData,
   output logic [15:0]                instruction,
   output logic [15:0]                pcPlus2,
   output logic                       halted
);

   import procPkg::*;

   logic [15:0] pc;
   logic [15:0] iMem [iMemWords];
   logic [15:0] memWord;

   // Program counter, frozen once the core has halted
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= 16'h0000;
      end else if (!halted) begin
         pc <= nextPc;
      end
   end

   // Halt latch, only reset brings the core back
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (isHalt) begin
         halted <= 1'b1;
      end
   end

   // Loader write port
   always_ff @(posedge clk) begin
      if (progWe) begin
         iMem[progAddr] <= progData;
      end
   end

   // Word index is byte address bits 8 to 1
   assign memWord = iMem[pc[iAddrW:1]];

   // Feed NOPs after halt so nothing downstream commits
   assign instruction = halted ? {opNop, 11'b0} : memWord;

   assign pcPlus2 = pc + 16'd2;

endmodule

// ==== verilog/procPkg.sv ====
package procPkg;

   // Primary opcode, instruction bits 15 to 11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opLbi   = 5'b11000,
      opAlur  = 5'b11011
   } opcodeT;

   // Function field of register-register ALU instructions
   typedef enum logic [1:0] {
      funcAdd  = 2'b00,
      funcSub  = 2'b01,
      funcXor  = 2'b10,
      funcAndn = 2'b11
   } aluFuncT;

   // Operation carried out by the execute stage
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluAndn,
      aluPassB,
      aluShlB
   } aluOpT;

   // Source of the register write data
   typedef enum logic {
      wbAlu,
      wbMem
   } wbSelT;

   // Instruction field positions
   localparam int opMsb   = 15;
   localparam int opLsb   = 11;
   localparam int rsMsb   = 10;
   localparam int rsLsb   = 8;
   localparam int rtMsb   = 7;
   localparam int rtLsb   = 5;
   localparam int rdMsb   = 4;
   localparam int rdLsb   = 2;
   localparam int funcMsb = 1;
   localparam int funcLsb = 0;
   localparam int imm5Msb = 4;
   localparam int imm8Msb = 7;
   localparam int dispMsb = 10;

   // Memory depths in 16-bit words, indexed by byte address bits 8 to 1
   localparam int iMemWords = 256;
   localparam int dMemWords = 256;
   localparam int iAddrW    = $clog2(iMemWords);
   localparam int dAddrW    = $clog2(dMemWords);

endpackage
